// ==== verilog/ov5640_cfg_pkg.sv ====
// Sensor constants, transaction types and fixed register rows shared by the OV5640 config RTL
package ov5640_cfg_pkg;

    // One SCCB register write or read, address in the upper 16 bits
    typedef struct packed {
        logic [15:0] reg_addr;
        logic [7:0]  reg_data;
    } cfg_word_t;

    typedef logic [7:0] cfg_index_t;  // Transaction number

    localparam int cfg_reg_count    = 72;  // Includes the two ID reads
    localparam int id_read_count    = 2;
    localparam int window_row_count = 8;   // Computed rows 0x3808 to 0x380F

    localparam logic [15:0] sensor_chip_id = 16'h5640;
    localparam logic [15:0] id_high_addr   = 16'h300A;
    localparam logic [15:0] id_low_addr    = 16'h300B;

    // Blanking added to the active window to get the frame totals
    localparam logic [12:0] h_blank_pixels = 13'd1216;
    localparam logic [12:0] v_blank_lines  = 13'd504;

    typedef enum logic [1:0] {
        seq_power_wait,
        seq_issue,
        seq_wait_done,
        seq_finished
    } seq_state_t;

    // ------------------------------
    // Fixed rows in issue order, with the computed window rows taken out
    // ------------------------------
    localparam cfg_word_t fixed_rows [cfg_reg_count - window_row_count] = '{
        // Chip ID, high byte first
        '{id_high_addr, 8'h00}, '{id_low_addr, 8'h00},
        // Soft reset, wake-up, PLL clock source
        '{16'h3008, 8'h82}, '{16'h3008, 8'h02}, '{16'h3103, 8'h02},
        // Pad direction for sync, PCLK and data
        '{16'h3017, 8'hFF}, '{16'h3018, 8'hFF},
        // PLL pre-divider and root divider
        '{16'h3037, 8'h13}, '{16'h3108, 8'h01},
        // Analog and system setup
        '{16'h3630, 8'h36}, '{16'h3631, 8'h0E}, '{16'h3632, 8'hE2}, '{16'h3633, 8'h12},
        '{16'h3621, 8'hE0}, '{16'h3704, 8'hA0}, '{16'h3703, 8'h5A}, '{16'h3715, 8'h78},
        '{16'h3717, 8'h01}, '{16'h370B, 8'h60}, '{16'h3705, 8'h1A}, '{16'h3905, 8'h02},
        '{16'h3906, 8'h10}, '{16'h3901, 8'h0A}, '{16'h3731, 8'h12}, '{16'h302D, 8'h60},
        '{16'h3620, 8'h52}, '{16'h371B, 8'h20}, '{16'h471C, 8'h50}, '{16'h3635, 8'h13},
        '{16'h3636, 8'h03}, '{16'h3634, 8'h40}, '{16'h3622, 8'h01}, '{16'h3708, 8'h64},
        '{16'h4001, 8'h02}, '{16'h4005, 8'h1A},
        // Block reset release, clock enables
        '{16'h3000, 8'h00}, '{16'h3004, 8'hFF},
        // RGB565 format, ISP in RGB mode
        '{16'h4300, 8'h61}, '{16'h501F, 8'h01}, '{16'h440E, 8'h00}, '{16'h5000, 8'hA7},
        // System clock divider, PLL multiplier
        '{16'h3035, 8'h11}, '{16'h3036, 8'h3C},
        // Timing block, subsampling and array window
        '{16'h3820, 8'h46}, '{16'h3821, 8'h01}, '{16'h3814, 8'h31}, '{16'h3815, 8'h31},
        '{16'h3800, 8'h00}, '{16'h3801, 8'h00}, '{16'h3802, 8'h00}, '{16'h3803, 8'h04},
        '{16'h3804, 8'h0A}, '{16'h3805, 8'h3F}, '{16'h3806, 8'h07}, '{16'h3807, 8'h9B},
        // Window offsets, after the computed size rows
        '{16'h3813, 8'h06}, '{16'h3810, 8'h00}, '{16'h3811, 8'h10}, '{16'h3812, 8'h00},
        // DVP clock dividers
        '{16'h4837, 8'h22}, '{16'h3824, 8'h02}, '{16'h460C, 8'h22},
        // ISP control, normal mode without colour bar
        '{16'h5001, 8'hA3}, '{16'h503D, 8'h00}
    };

endpackage

// ==== verilog/ov5640_reg_table.sv ====
// Read-only register table, maps a transaction index to its address and data word
`timescale 1ns/1ns

module ov5640_reg_table
    import ov5640_cfg_pkg::*;
#(
    parameter logic [23:0] cmos_h_pixel = 24'd1024,
    parameter logic [23:0] cmos_v_pixel = 24'd768
) (
    input  cfg_index_t index,
    output cfg_word_t  word
);

    // ------------------------------
    // Table layout
    // ------------------------------
    localparam int fixed_row_count = cfg_reg_count - window_row_count;
    localparam int fixed_bits      = $clog2(fixed_row_count);
    localparam int window_bits     = $clog2(window_row_count);

    localparam cfg_index_t window_first_index = 8'd55;  // Right after 0x3807
    localparam cfg_index_t window_end_index   = window_first_index
                                                + cfg_index_t'(window_row_count);
    localparam logic [15:0] window_base_addr  = 16'h3808;

    // Frame totals
    localparam logic [23:0] total_h_pixel = cmos_h_pixel + 24'(h_blank_pixels);
    localparam logic [23:0] total_v_pixel = cmos_v_pixel + 24'(v_blank_lines);

    // Data bytes for 0x3808 .. 0x380F, high byte before low byte
    localparam logic [7:0] window_bytes [window_row_count] = '{
        {4'd0, cmos_h_pixel[11:8]},   // DVP width, 4 high bits
        cmos_h_pixel[7:0],
        {5'd0, cmos_v_pixel[10:8]},   // DVP height, 3 high bits
        cmos_v_pixel[7:0],
        {3'd0, total_h_pixel[12:8]},  // HTS
        total_h_pixel[7:0],
        {3'd0, total_v_pixel[12:8]},  // VTS
        total_v_pixel[7:0]
    };

    logic [window_bits-1:0] window_offset;
    logic [fixed_bits-1:0]  fixed_index;
    logic                   in_window;
    logic                   in_table;

    assign in_table  = (index < cfg_index_t'(cfg_reg_count));
    assign in_window = (index >= window_first_index) && (index < window_end_index);

    // Rows past the window sit eight places lower in fixed_rows
    always_comb begin
        window_offset = window_bits'(index - window_first_index);
        if (index < window_first_index) begin
            fixed_index = fixed_bits'(index);
        end else begin
            fixed_index = fixed_bits'(index - cfg_index_t'(window_row_count));
        end
    end

    always_comb begin
        if (!in_table) begin
            // Harmless read so a stray index never rewrites a register
            word = '{reg_addr: id_high_addr, reg_data: 8'h00};
        end else if (in_window) begin
            word.reg_addr = window_base_addr + 16'(window_offset);
            word.reg_data = window_bytes[window_offset];
        end else begin
            word = fixed_rows[fixed_index];
        end
    end

endmodule

// ==== verilog/ov5640_init_sequencer.sv ====
// Power-up delay and transaction FSM that steps the I2C master through the register table
`timescale 1ns/1ns

module ov5640_init_sequencer
    import ov5640_cfg_pkg::*;
#(
    parameter logic [12:0] power_up_cycles = 13'd5000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i2c_done,
    input  cfg_word_t  table_word,
    output cfg_index_t table_index,
    output logic       i2c_exec,
    output cfg_word_t  i2c_word,
    output logic       i2c_rh_wl,
    output logic       init_done
);

    seq_state_t  state;
    logic [12:0] wait_cnt;     // Power-up delay
    cfg_index_t  tx_index;     // Transactions issued so far
    logic        wait_over;
    logic        more_to_send;
    logic        start_tx;

    // Sensor needs its supply and clock stable before the first SCCB access
    assign wait_over    = (wait_cnt == power_up_cycles - 13'd1);
    assign more_to_send = (tx_index < cfg_index_t'(cfg_reg_count));

    // Launch on the last wait cycle, or right on a done with rows left
    assign start_tx = ((state == seq_power_wait) && wait_over)
                    || ((state == seq_wait_done) && i2c_done && more_to_send);

    assign table_index = tx_index;

    // ------------------------------
    // Transaction FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= seq_power_wait;
            wait_cnt  <= '0;
            tx_index  <= '0;
            i2c_exec  <= 1'b0;
            i2c_rh_wl <= 1'b1;
            init_done <= 1'b0;
        end else begin
            i2c_exec <= start_tx;  // One pulse per transaction
            if (start_tx) begin
                i2c_rh_wl <= (tx_index < cfg_index_t'(id_read_count));
            end

            case (state)
                seq_power_wait: begin
                    wait_cnt <= wait_cnt + 13'd1;
                    if (wait_over) begin
                        state <= seq_issue;
                    end
                end
                seq_issue: begin
                    // Exec is high in this cycle
                    tx_index <= tx_index + cfg_index_t'(1);
                    state    <= seq_wait_done;
                end
                seq_wait_done: begin
                    if (i2c_done) begin
                        if (more_to_send) begin
                            state <= seq_issue;
                        end else begin
                            state     <= seq_finished;
                            init_done <= 1'b1;
                        end
                    end
                end
                seq_finished: begin
                    init_done <= 1'b1;  // Holds until next reset
                end
                default: begin
                    state <= seq_power_wait;
                end
            endcase
        end
    end

    // Word stays put from exec until the matching done
    always_ff @(posedge clk) begin
        if (start_tx) begin
            i2c_word <= table_word;
        end
    end

    // ------------------------------
    // Handshake checks
    // ------------------------------
    exec_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        i2c_exec |=> !i2c_exec
    ) else $error("i2c_exec held for more than one cycle");

    // Exec belongs to the issue state, never to the wait for the master
    exec_waits_for_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == seq_wait_done) |-> !i2c_exec
    ) else $error("i2c_exec issued while a transaction was pending");

    exec_stops_at_init_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        init_done |=> (init_done && !i2c_exec)
    ) else $error("i2c_exec after init_done, or init_done dropped");

endmodule

// ==== verilog/ov5640_id_check.sv ====
// Collects the two chip-ID bytes from the leading reads and flags an OV5640 match
`timescale 1ns/1ns

module ov5640_id_check
    import ov5640_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i2c_done,
    input  logic       i2c_rh_wl,
    input  logic [7:0] i2c_rd_data,
    output logic       id_flag
);

    logic [1:0] read_cnt;      // Read completions seen
    logic [7:0] id_high_byte;  // First byte returned, from 0x300A
    logic       read_done;
    logic       last_read;

    assign read_done = i2c_done && i2c_rh_wl;
    assign last_read = read_done && (read_cnt == 2'(id_read_count - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_cnt <= '0;
            id_flag  <= 1'b0;
        end else if (read_done && (read_cnt < 2'(id_read_count))) begin
            read_cnt <= read_cnt + 2'd1;
            if (last_read) begin
                id_flag <= ({id_high_byte, i2c_rd_data} == sensor_chip_id);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_done && (read_cnt == 2'd0)) begin
            id_high_byte <= i2c_rd_data;
        end
    end

    // Sequencer switches to writes after the ID reads
    no_third_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read_cnt == 2'(id_read_count)) |-> !read_done
    ) else $error("Read completion after the two chip-ID bytes");

endmodule

// ==== verilog/ov5640_cfg_top.sv ====
// Top of the OV5640 power-up configuration block, connects table, sequencer and ID check
`timescale 1ns/1ns

module ov5640_cfg_top
    import ov5640_cfg_pkg::*;
#(
    parameter logic [23:0] cmos_h_pixel    = 24'd1024,
    parameter logic [23:0] cmos_v_pixel    = 24'd768,
    parameter logic [12:0] power_up_cycles = 13'd5000  // Cycles before the first access
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] i2c_rd_data,
    input  logic       i2c_done,
    output logic       i2c_exec,
    output cfg_word_t  i2c_word,
    output logic       i2c_rh_wl,
    output logic       init_done,
    output logic       id_flag
);

    cfg_index_t table_index;
    cfg_word_t  table_word;

    ov5640_reg_table #(
        .cmos_h_pixel(cmos_h_pixel),
        .cmos_v_pixel(cmos_v_pixel)
    ) ov5640_reg_table_inst (
        .index(table_index),
        .word (table_word)
    );

    ov5640_init_sequencer #(
        .power_up_cycles(power_up_cycles)
    ) ov5640_init_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i2c_done   (i2c_done),
        .table_word (table_word),
        .table_index(table_index),
        .i2c_exec   (i2c_exec),
        .i2c_word   (i2c_word),
        .i2c_rh_wl  (i2c_rh_wl),
        .init_done  (init_done)
    );

    // Uses the registered direction so it matches the pending transaction
    ov5640_id_check ov5640_id_check_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i2c_done   (i2c_done),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_rd_data(i2c_rd_data),
        .id_flag    (id_flag)
    );

endmodule

// ==== verification/i2c_master_model.sv ====
// Stand-in for the I2C master and sensor, answers each exec with a delayed done and the ID bytes
`timescale 1ns/1ns

module i2c_master_model #(
    parameter int rand_seed = 5
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exec,
    input  logic        rh_wl,
    input  logic [15:0] chip_id,    // ID returned by the two reads
    output logic        done,
    output logic [7:0]  rd_data
);

    int unsigned countdown;  // Cycles left until done
    int          read_num;   // Reads answered since reset
    logic        pending_read;

    // Single process, so one seed covers every delay drawn
    initial begin
        done         = 1'b0;
        rd_data      = 8'h00;
        countdown    = 0;
        read_num     = 0;
        pending_read = 1'b0;
        void'($urandom(rand_seed));
        forever begin
            @(negedge clk);
            done = 1'b0;  // Done is a one-cycle pulse
            if (!rst_n) begin
                countdown = 0;
                read_num  = 0;
            end else if (exec) begin
                countdown    = 1 + ($urandom % 8);  // 1 to 8 cycles
                pending_read = rh_wl;
            end else if (countdown == 1) begin
                countdown = 0;
                done      = 1'b1;
                if (pending_read) begin
                    // High byte comes from the first read
                    rd_data  = (read_num == 0) ? chip_id[15:8] : chip_id[7:0];
                    read_num = read_num + 1;
                end else begin
                    rd_data = 8'hA5;  // Junk on writes
                end
            end else if (countdown != 0) begin
                countdown = countdown - 1;
            end
        end
    end

endmodule

// ==== verification/ov5640_cfg_tb.sv ====
// Testbench for the OV5640 config block, runs the power-up sequence once per chip ID value
`timescale 1ns/1ns

module ov5640_cfg_tb
    import ov5640_cfg_pkg::*;
();

    localparam int tb_power_up   = 40;
    localparam int tb_h_pixel    = 1024;  // Same as the DUT defaults
    localparam int tb_v_pixel    = 768;
    localparam int tb_h_blank    = 1216;
    localparam int tb_v_blank    = 504;
    localparam int run_timeout   = 2000;  // Cycles per run
    localparam int settle_cycles = 20;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [7:0]  i2c_rd_data;
    logic        i2c_done;
    logic        i2c_exec;
    cfg_word_t   i2c_word;
    logic        i2c_rh_wl;
    logic        init_done;
    logic        id_flag;
    logic [15:0] model_chip_id = 16'h0000;
    logic        id_expected = 1'b0;

    int         cycle_cnt;    // Rising edges since reset release
    int         exec_cnt;     // Execs so far in this run
    int         done_cnt;
    logic [7:0] window_seen;  // One bit per register 0x3808 to 0x380F
    int         error_count = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    logic       timed_out = 1'b0;

    always #4 clk = ~clk;

    ov5640_cfg_top #(
        .power_up_cycles(13'(tb_power_up))
    ) ov5640_cfg_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i2c_rd_data(i2c_rd_data),
        .i2c_done   (i2c_done),
        .i2c_exec   (i2c_exec),
        .i2c_word   (i2c_word),
        .i2c_rh_wl  (i2c_rh_wl),
        .init_done  (init_done),
        .id_flag    (id_flag)
    );

    i2c_master_model #(
        .rand_seed(5)
    ) i2c_master_model_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .exec   (i2c_exec),
        .rh_wl  (i2c_rh_wl),
        .chip_id(model_chip_id),
        .done   (i2c_done),
        .rd_data(i2c_rd_data)
    );

    // ------------------------------
    // Expected values and reporting
    // ------------------------------
    function automatic logic is_window_addr(input logic [15:0] addr);
        return (addr >= 16'h3808) && (addr <= 16'h380F);
    endfunction

    // Even address carries the high byte
    function automatic logic [7:0] expected_window_byte(input logic [15:0] addr);
        int value;
        case (addr[2:1])
            2'd0:    value = tb_h_pixel;
            2'd1:    value = tb_v_pixel;
            2'd2:    value = tb_h_pixel + tb_h_blank;  // HTS
            default: value = tb_v_pixel + tb_v_blank;  // VTS
        endcase
        if (addr[0]) begin
            return value[7:0];
        end
        return value[15:8];
    endfunction

    function automatic logic [15:0] expected_read_addr(input int n);
        return (n == 0) ? id_high_addr : id_low_addr;
    endfunction

    task automatic report_value(input string sig, input int expected, input int actual);
        $display("ERR t=%0t %s expected=%0h got=%0h", $time, sig, expected, actual);
        error_count = error_count + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at t=%0t: %s", $time, what);
        error_count = error_count + 1;
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt   <= 0;
            exec_cnt    <= 0;
            done_cnt    <= 0;
            window_seen <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (i2c_exec) begin
                exec_cnt <= exec_cnt + 1;
                if (is_window_addr(i2c_word.reg_addr)) begin
                    window_seen[i2c_word.reg_addr[2:0]] <= 1'b1;
                end
            end
            if (i2c_done) begin
                done_cnt <= done_cnt + 1;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    no_early_exec: assert property (@(posedge clk) disable iff (!rst_n)
        (cycle_cnt < tb_power_up) |-> !i2c_exec)
        else report_value("i2c_exec", 0, int'($sampled(i2c_exec)));
    first_exec_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        (cycle_cnt == tb_power_up) |-> i2c_exec)
        else report_value("i2c_exec", 1, int'($sampled(i2c_exec)));
    exec_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_done && (exec_cnt < cfg_reg_count)) |=> i2c_exec)
        else report_value("i2c_exec", 1, int'($sampled(i2c_exec)));
    exec_only_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_exec && (exec_cnt > 0)) |-> $past(i2c_done))
        else report_failure("i2c_exec issued without a done in the cycle before");
    read_direction: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_exec && (exec_cnt < id_read_count)) |-> i2c_rh_wl)
        else report_value("i2c_rh_wl", 1, int'($sampled(i2c_rh_wl)));
    write_direction: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_exec && (exec_cnt >= id_read_count)) |-> !i2c_rh_wl)
        else report_value("i2c_rh_wl", 0, int'($sampled(i2c_rh_wl)));
    read_address: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_exec && (exec_cnt < id_read_count))
            |-> (i2c_word.reg_addr == expected_read_addr(exec_cnt)))
        else report_value("i2c_word.reg_addr", int'(expected_read_addr($sampled(exec_cnt))),
                          int'($sampled(i2c_word.reg_addr)));
    window_data: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_exec && is_window_addr(i2c_word.reg_addr))
            |-> (i2c_word.reg_data == expected_window_byte(i2c_word.reg_addr)))
        else report_value("i2c_word.reg_data",
                          int'(expected_window_byte($sampled(i2c_word.reg_addr))),
                          int'($sampled(i2c_word.reg_data)));
    exec_limit: assert property (@(posedge clk) disable iff (!rst_n)
        i2c_exec |-> (exec_cnt < cfg_reg_count))
        else report_failure("More execs than table entries");
    init_done_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        (i2c_done && (exec_cnt == cfg_reg_count)) |=> init_done)
        else report_value("init_done", 1, int'($sampled(init_done)));
    init_done_not_early: assert property (@(posedge clk) disable iff (!rst_n)
        (done_cnt < cfg_reg_count) |-> !init_done)
        else report_value("init_done", 0, int'($sampled(init_done)));
    init_done_holds: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done)
        else report_value("init_done", 1, int'($sampled(init_done)));
    no_exec_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |-> !i2c_exec)
        else report_value("i2c_exec", 0, int'($sampled(i2c_exec)));
    all_window_rows: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |-> (window_seen == 8'hFF))
        else report_failure("Not every window register 0x3808 to 0x380F was written");
    id_flag_result: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |-> (id_flag == id_expected))
        else report_value("id_flag", int'($sampled(id_expected)), int'($sampled(id_flag)));

    // ------------------------------
    // Test sequence
    // ------------------------------
    task automatic run_test(input string name, input logic [15:0] chip_id);
        int errors_before;
        int waited;
        errors_before = error_count;
        tests_run     = tests_run + 1;
        @(negedge clk);
        rst_n         = 1'b0;
        model_chip_id = chip_id;
        id_expected   = (chip_id == sensor_chip_id);
        repeat (2) @(negedge clk);
        rst_n  = 1'b1;
        waited = 0;
        while (!init_done && (waited < run_timeout)) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!init_done) begin
            report_failure($sformatf("Timeout, init_done not seen within %0d cycles",
                                     run_timeout));
            timed_out = 1'b1;
        end else begin
            repeat (settle_cycles) @(negedge clk);  // Watch for stray execs
        end
        if (error_count != errors_before) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %s: %s, %0d execs, %0d errors", name,
                 (error_count == errors_before) ? "passed" : "failed",
                 exec_cnt, error_count - errors_before);
    endtask

    initial begin
        run_test("chip ID 0x5640", 16'h5640);
        if (!timed_out) begin
            run_test("chip ID 0x1234", 16'h1234);
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/ov5640_cfg_pkg.sv
verilog/ov5640_reg_table.sv
verilog/ov5640_init_sequencer.sv
verilog/ov5640_id_check.sv
verilog/ov5640_cfg_top.sv
verification/i2c_master_model.sv
verification/ov5640_cfg_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILE_LIST  := compile.f
TB_TOP     := ov5640_cfg_tb
RTL_TOP    := ov5640_cfg_top
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qxF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
